// ==== hdl/odo_macros.svh ====
`ifndef ODO_MACROS_SVH
`define ODO_MACROS_SVH

// ======================================================================
// speed path
// ======================================================================
`define ODO_CHANNELS      4
`define ODO_SPEED_W       16
// short window for simulation, a real build uses a much longer one
`define ODO_WINDOW_CYCLES 200
`define ODO_CREDITS       4

// ======================================================================
// beacon path
// ======================================================================
`define BCN_POS_W         16
// gaps shorter than this many laser edges are glitches
`define BCN_GAP_EDGES     20

`endif

// ==== hdl/odoPkg.sv ====
`include "odo_macros.svh"

package odoPkg;

	typedef logic [`ODO_SPEED_W-1:0] speed_t;   // speed or edge count
	typedef logic [1:0]              chanIdx_t;
	typedef logic [`BCN_POS_W-1:0]   bcnPos_t;  // turret position in laser edges

	typedef enum logic
	{
		dirReverse = 1'b0,
		dirForward = 1'b1   // B high on rising A
	} encDir_e;

	typedef enum logic [1:0]
	{
		bcnWait,
		bcnReception,
		bcnGap
	} bcnState_e;

endpackage

// ==== hdl/encoderSampler.sv ====
`include "odo_macros.svh"

module encoderSampler import odoPkg::*;
(
	input  logic                     CLOCK_50,
	input  logic                     reset,
	input  logic [`ODO_CHANNELS-1:0] encA,
	input  logic [`ODO_CHANNELS-1:0] encB,
	input  logic                     laserA,
	input  logic                     laserSync,
	input  logic                     laserSign,
	output logic [`ODO_CHANNELS-1:0] edgeA,
	output logic [`ODO_CHANNELS-1:0] edgeB,
	output logic [`ODO_CHANNELS-1:0] levelB,
	output logic                     laserEdge,
	output logic                     syncEdge,
	output logic                     signLevel
);

	localparam int Chans = `ODO_CHANNELS;
	localparam int InW   = 2 * Chans + 3;

	logic [InW-1:0] rawIn;
	logic [InW-1:0] metaIn;   // first stage, may be metastable
	logic [InW-1:0] syncIn;
	logic [InW-1:0] prevIn;
	logic [InW-1:0] riseIn;

	// all asynchronous inputs in one vector
	assign rawIn = {laserSign, laserSync, laserA, encB, encA};

	always_ff @(posedge CLOCK_50, posedge reset)
	begin
		if (reset)
		begin
			metaIn <= '0;
			syncIn <= '0;
			prevIn <= '0;
		end
		else
		begin
			metaIn <= rawIn;
			syncIn <= metaIn;
			prevIn <= syncIn;
		end
	end

	assign riseIn = syncIn & ~prevIn;

	assign edgeA     = riseIn[Chans-1:0];
	assign edgeB     = riseIn[2*Chans-1:Chans];
	assign levelB    = syncIn[2*Chans-1:Chans];   // same depth as the edge pulses
	assign laserEdge = riseIn[2*Chans];
	assign syncEdge  = riseIn[2*Chans+1];
	assign signLevel = syncIn[2*Chans+2];

endmodule

// ==== hdl/speedChannel.sv ====
`include "odo_macros.svh"

module speedChannel import odoPkg::*;
(
	input  logic    CLOCK_50,
	input  logic    reset,
	input  logic    edgeA,
	input  logic    edgeB,
	input  logic    levelB,
	input  logic    windowEnd,
	input  logic    take,
	output logic    pending,
	output speed_t  speed,
	output encDir_e dir,
	output logic    overrunHit
);

	speed_t                countA;
	speed_t                countB;
	encDir_e               dirNow;
	logic [`ODO_SPEED_W:0] edgeSum;   // one extra bit so the sum cannot wrap

	assign edgeSum = {1'b0, countA} + {1'b0, countB};

	// result still unread when the next one lands
	assign overrunHit = windowEnd & pending & ~take;

	always_ff @(posedge CLOCK_50, posedge reset)
	begin
		if (reset)
		begin
			countA <= '0;
			countB <= '0;
			dirNow <= dirForward;
		end
		else
		begin
			if (windowEnd)
			begin
				// an edge in the boundary cycle belongs to the new window
				countA <= speed_t'(edgeA);
				countB <= speed_t'(edgeB);
			end
			else
			begin
				countA <= countA + speed_t'(edgeA);
				countB <= countB + speed_t'(edgeB);
			end
			if (edgeA)
				dirNow <= levelB ? dirForward : dirReverse;
		end
	end

	always_ff @(posedge CLOCK_50, posedge reset)
	begin
		if (reset)
			pending <= 1'b0;
		else if (windowEnd)
			pending <= 1'b1;   // wins over take, new result waits
		else if (take)
			pending <= 1'b0;
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (windowEnd)
		begin
			speed <= edgeSum[`ODO_SPEED_W:1];   // average of A and B counts
			dir   <= dirNow;
		end
	end

endmodule

// ==== hdl/reportArbiter.sv ====
`include "odo_macros.svh"

module reportArbiter import odoPkg::*;
(
	input  logic                     CLOCK_50,
	input  logic                     reset,
	input  logic [`ODO_CHANNELS-1:0] pending,
	input  speed_t                   speed [`ODO_CHANNELS],
	input  encDir_e                  dir [`ODO_CHANNELS],
	input  logic [`ODO_CHANNELS-1:0] overrunHit,
	input  logic                     creditReturn,
	output logic                     windowEnd,
	output logic [`ODO_CHANNELS-1:0] take,
	output logic                     reportValid,
	output chanIdx_t                 reportChannel,
	output speed_t                   reportSpeed,
	output encDir_e                  reportDir,
	output logic                     overrun
);

	localparam int Chans = `ODO_CHANNELS;
	localparam int WinW  = $clog2(`ODO_WINDOW_CYCLES);
	localparam int CredW = $clog2(`ODO_CREDITS + 1);

	logic [WinW-1:0]  winCount;
	logic [CredW-1:0] creditCount;
	chanIdx_t         pick;

	// ======================================================================
	// measurement window
	// ======================================================================
	assign windowEnd = (winCount == WinW'(`ODO_WINDOW_CYCLES - 1));

	always_ff @(posedge CLOCK_50, posedge reset)
	begin
		if (reset)
			winCount <= '0;
		else if (windowEnd)
			winCount <= '0;
		else
			winCount <= winCount + 1'b1;
	end

	// ======================================================================
	// report selection
	// ======================================================================
	always_comb
	begin
		pick = '0;
		for (int i = Chans - 1; i >= 0; i--)   // last hit is the lowest index
			if (pending[i])
				pick = chanIdx_t'(i);
	end

	assign reportValid   = (creditCount != '0) & (|pending);
	assign take          = reportValid ? (Chans'(1) << pick) : '0;
	assign reportChannel = pick;
	assign reportSpeed   = speed[pick];
	assign reportDir     = dir[pick];

	// ======================================================================
	// credits and overrun
	// ======================================================================
	always_ff @(posedge CLOCK_50, posedge reset)
	begin
		if (reset)
			creditCount <= CredW'(`ODO_CREDITS);
		else if (reportValid && !creditReturn)
			creditCount <= creditCount - 1'b1;
		else if (!reportValid && creditReturn)
			creditCount <= creditCount + 1'b1;
	end

	always_ff @(posedge CLOCK_50, posedge reset)
	begin
		if (reset)
			overrun <= 1'b0;
		else if (|overrunHit)
			overrun <= 1'b1;   // sticky until reset
	end

endmodule

// ==== hdl/beaconTracker.sv ====
`include "odo_macros.svh"

module beaconTracker import odoPkg::*;
(
	input  logic    CLOCK_50,
	input  logic    reset,
	input  logic    laserEdge,
	input  logic    syncEdge,
	input  logic    signLevel,
	output logic    beaconValid,
	output bcnPos_t beaconStart,
	output bcnPos_t beaconEnd
);

	localparam int GapW = $clog2(`BCN_GAP_EDGES + 1);

	bcnState_e       state;
	bcnPos_t         position;
	bcnPos_t         candEnd;   // end of reception if the gap holds
	logic [GapW-1:0] gapCount;
	logic            gapDone;

	assign gapDone = (state == bcnGap) && !signLevel
		&& (gapCount == GapW'(`BCN_GAP_EDGES));

	// turret position, zero at the sync mark
	always_ff @(posedge CLOCK_50, posedge reset)
	begin
		if (reset)
			position <= '0;
		else if (syncEdge)
			position <= '0;
		else if (laserEdge)
			position <= position + 1'b1;
	end

	always_ff @(posedge CLOCK_50, posedge reset)
	begin
		if (reset)
		begin
			state       <= bcnWait;
			gapCount    <= '0;
			beaconValid <= 1'b0;
		end
		else
		begin
			beaconValid <= 1'b0;
			case (state)
				bcnWait:
					if (signLevel)
						state <= bcnReception;
				bcnReception:
					if (!signLevel)
					begin
						state    <= bcnGap;
						gapCount <= '0;
					end
				bcnGap:
					if (signLevel)
						state <= bcnReception;   // short dropout, same beacon
					else if (gapDone)
					begin
						beaconValid <= 1'b1;
						state       <= bcnWait;
					end
					else if (laserEdge)
						gapCount <= gapCount + 1'b1;
				default:
					state <= bcnWait;
			endcase
		end
	end

	// positions captured along the reception
	always_ff @(posedge CLOCK_50)
	begin
		if (state == bcnWait && signLevel)
			beaconStart <= position;
		if (state == bcnReception && !signLevel)
			candEnd <= position;
		if (gapDone)
			beaconEnd <= candEnd;
	end

endmodule

// ==== hdl/odometryTop.sv ====
`include "odo_macros.svh"

module odometryTop import odoPkg::*;
(
	input  logic                     CLOCK_50,
	input  logic                     reset,
	input  logic [`ODO_CHANNELS-1:0] encA,
	input  logic [`ODO_CHANNELS-1:0] encB,
	input  logic                     laserA,
	input  logic                     laserSync,
	input  logic                     laserSign,
	input  logic                     creditReturn,
	output logic                     reportValid,
	output chanIdx_t                 reportChannel,
	output speed_t                   reportSpeed,
	output encDir_e                  reportDir,
	output logic                     overrun,
	output logic                     beaconValid,
	output bcnPos_t                  beaconStart,
	output bcnPos_t                  beaconEnd
);

	logic [`ODO_CHANNELS-1:0] edgeA;
	logic [`ODO_CHANNELS-1:0] edgeB;
	logic [`ODO_CHANNELS-1:0] levelB;
	logic [`ODO_CHANNELS-1:0] take;
	logic [`ODO_CHANNELS-1:0] pending;
	logic [`ODO_CHANNELS-1:0] overrunHit;
	speed_t                   chanSpeed [`ODO_CHANNELS];
	encDir_e                  chanDir [`ODO_CHANNELS];
	logic                     windowEnd;
	logic                     laserEdge;
	logic                     syncEdge;
	logic                     signLevel;

	encoderSampler i_sampler
	(
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.encA      (encA),
		.encB      (encB),
		.laserA    (laserA),
		.laserSync (laserSync),
		.laserSign (laserSign),
		.edgeA     (edgeA),
		.edgeB     (edgeB),
		.levelB    (levelB),
		.laserEdge (laserEdge),
		.syncEdge  (syncEdge),
		.signLevel (signLevel)
	);

	// propulsion left/right, then odometer left/right
	for (genvar g = 0; g < `ODO_CHANNELS; g++)
	begin : gChan
		speedChannel i_chan
		(
			.CLOCK_50   (CLOCK_50),
			.reset      (reset),
			.edgeA      (edgeA[g]),
			.edgeB      (edgeB[g]),
			.levelB     (levelB[g]),
			.windowEnd  (windowEnd),
			.take       (take[g]),
			.pending    (pending[g]),
			.speed      (chanSpeed[g]),
			.dir        (chanDir[g]),
			.overrunHit (overrunHit[g])
		);
	end

	reportArbiter i_arbiter
	(
		.CLOCK_50      (CLOCK_50),
		.reset         (reset),
		.pending       (pending),
		.speed         (chanSpeed),
		.dir           (chanDir),
		.overrunHit    (overrunHit),
		.creditReturn  (creditReturn),
		.windowEnd     (windowEnd),
		.take          (take),
		.reportValid   (reportValid),
		.reportChannel (reportChannel),
		.reportSpeed   (reportSpeed),
		.reportDir     (reportDir),
		.overrun       (overrun)
	);

	beaconTracker i_beacon
	(
		.CLOCK_50    (CLOCK_50),
		.reset       (reset),
		.laserEdge   (laserEdge),
		.syncEdge    (syncEdge),
		.signLevel   (signLevel),
		.beaconValid (beaconValid),
		.beaconStart (beaconStart),
		.beaconEnd   (beaconEnd)
	);

endmodule

// ==== verif/odometryTop_props.sv ====
`include "odo_macros.svh"

module odometryTop_props
(
	input logic                                 CLOCK_50,
	input logic                                 reset,
	input logic                                 reportValid,
	input logic [`ODO_CHANNELS-1:0]             take,
	input logic [$clog2(`ODO_CREDITS + 1)-1:0]  creditCount
);

	// a report always spends a credit that exists
	creditNeeded: assert property (@(posedge CLOCK_50) disable iff (reset)
		reportValid |-> creditCount != '0)
		else $error("report issued with the credit count at zero");

	creditBound: assert property (@(posedge CLOCK_50) disable iff (reset)
		creditCount <= `ODO_CREDITS)
		else $error("credit count above the granted number");

	takeOneHot: assert property (@(posedge CLOCK_50) disable iff (reset)
		$onehot0(take))
		else $error("more than one channel taken in a cycle");

endmodule

bind reportArbiter odometryTop_props i_props
(
	.CLOCK_50    (CLOCK_50),
	.reset       (reset),
	.reportValid (reportValid),
	.take        (take),
	.creditCount (creditCount)
);

// ==== verif/odometryTop_tb.sv ====
`include "odo_macros.svh"

module odometryTop_tb import odoPkg::*;
();

	localparam int Chans      = `ODO_CHANNELS;
	localparam int Window     = `ODO_WINDOW_CYCLES;
	localparam int DriveStart = 30;   // first encoder step after a window boundary

	logic             CLOCK_50;
	logic             reset;
	logic [Chans-1:0] encA;
	logic [Chans-1:0] encB;
	logic             laserA;
	logic             laserSync;
	logic             laserSign;
	logic             creditReturn;
	logic             reportValid;
	chanIdx_t         reportChannel;
	speed_t           reportSpeed;
	encDir_e          reportDir;
	logic             overrun;
	logic             beaconValid;
	bcnPos_t          beaconStart;
	bcnPos_t          beaconEnd;

	int    cyc;
	int    cycLimit;
	int    testErrors;
	int    passed;
	int    failed;
	bit    withhold;        // receiver keeps its credits
	bit    lostWindow;
	bit    expectOverrun;
	int    kept;
	int    returnDue[$];
	int    repChan[$];
	int    repSpeed[$];
	int    repDir[$];
	int    bcnStart[$];
	int    bcnEnd[$];
	int    cycles [Chans];
	int    dirs [Chans];
	string recs[$];

	odometryTop i_dut (.*);

	initial
	begin
		CLOCK_50 = 1'b0;
		forever #2 CLOCK_50 = ~CLOCK_50;
	end

	// cycles since reset release, also the run limit
	always @(posedge CLOCK_50)
	begin
		if (!reset)
			cyc <= cyc + 1;
		if (cycLimit != 0 && cyc > cycLimit)
		begin
			$display("timeout, no progress after %0d cycles", cyc);
			$display("Test FAILED");
			$finish;
		end
	end

	// ======================================================================
	// receiver model and output monitor
	// ======================================================================
	always @(negedge CLOCK_50)
	begin
		if (reportValid)
		begin
			repChan.push_back(int'(reportChannel));
			repSpeed.push_back(int'(reportSpeed));
			repDir.push_back(int'(reportDir));
			if (withhold)
				kept++;
			else
				returnDue.push_back(cyc + 3);
		end
		while (!withhold && kept > 0)   // hand back what was held
		begin
			returnDue.push_back(cyc + 2);
			kept--;
		end
		if (beaconValid)
		begin
			bcnStart.push_back(int'(beaconStart));
			bcnEnd.push_back(int'(beaconEnd));
		end
		creditReturn = 1'b0;
		if (returnDue.size() > 0 && returnDue[0] <= cyc)
		begin
			creditReturn = 1'b1;   // one credit per cycle
			void'(returnDue.pop_front());
		end
	end

	// ======================================================================
	// helpers
	// ======================================================================
	task automatic checkValue(string name, string what, int expected, int actual);
		assert (expected == actual)
		else
		begin
			$display("** Error %s: %s expected %0d, actual %0d", name, what, expected, actual);
			testErrors++;
		end
	endtask

	task automatic finishTest(string name);
		if (testErrors == 0)
			passed++;
		else
			failed++;
		$display("%s: %s", name, (testErrors == 0) ? "pass" : "fail");
		testErrors = 0;
	endtask

	task automatic waitWindowPhase(int phase);
		do
			@(negedge CLOCK_50);
		while (cyc % Window != phase);
	endtask

	task automatic setWithhold(bit value);
		@(posedge CLOCK_50);
		withhold = value;
	endtask

	task automatic laserStep();
		repeat (2) @(negedge CLOCK_50);
		laserA = 1'b1;
		repeat (2) @(negedge CLOCK_50);
		laserA = 1'b0;
	endtask

	// all channels in parallel, one phase change per step
	task automatic driveEncoders();
		int  maxN;
		int  step;
		int  s;
		logic lead;
		logic lag;
		maxN = 0;
		foreach (cycles[c])
			if (cycles[c] > maxN)
				maxN = cycles[c];
		for (step = 0; step < 4 * maxN; step++)
		begin
			s    = step % 4;
			lead = (s == 0 || s == 1);
			lag  = (s == 1 || s == 2);
			for (int c = 0; c < Chans; c++)
				if (step < 4 * cycles[c])
				begin
					encA[c] = (dirs[c] != 0) ? lag : lead;   // forward: B leads A
					encB[c] = (dirs[c] != 0) ? lead : lag;
				end
			repeat (2 + $urandom % 3) @(negedge CLOCK_50);
		end
	endtask

	task automatic collectReports(string name);
		int waited;
		waited = 0;
		while (repChan.size() < Chans && waited < 40)
		begin
			@(negedge CLOCK_50);
			waited++;
		end
		repeat (4) @(negedge CLOCK_50);
		assert (repChan.size() == Chans)
		else
		begin
			$display("%s: got %0d reports for the window instead of %0d",
				name, repChan.size(), Chans);
			testErrors++;
		end
		for (int c = 0; c < Chans && c < repChan.size(); c++)
		begin
			checkValue(name, $sformatf("report %0d channel", c), c, repChan[c]);
			checkValue(name, $sformatf("channel %0d speed", c), cycles[c], repSpeed[c]);
			checkValue(name, $sformatf("channel %0d direction", c), dirs[c], repDir[c]);
		end
	endtask

	// ======================================================================
	// test records
	// ======================================================================
	task automatic runSpeed(string line, string name);
		int mode;
		void'($sscanf(line, "S %d %d %d %d %d %d %d %d %d", mode, cycles[0], dirs[0],
			cycles[1], dirs[1], cycles[2], dirs[2], cycles[3], dirs[3]));
		if (mode != 0)
			setWithhold(1'b1);
		waitWindowPhase(DriveStart);
		repChan.delete();
		repSpeed.delete();
		repDir.delete();
		driveEncoders();
		waitWindowPhase(0);
		if (lostWindow)
			expectOverrun = 1'b1;   // a result was overwritten at this boundary
		lostWindow = (mode == 3);
		if (mode >= 2)
			repeat (8)
			begin
				assert (!reportValid)
				else
				begin
					$display("%s: report sent while all credits were held", name);
					testErrors++;
				end
				@(negedge CLOCK_50);
			end
		if (mode == 2)
			setWithhold(1'b0);
		if (mode != 3)
			collectReports(name);
		checkValue(name, "overrun", int'(expectOverrun), int'(overrun));
		finishTest(name);
	endtask

	task automatic runBeacon(string line, string name);
		int syncAt;
		int segs;
		int expStart;
		int expEnd;
		int lastPos;
		int waited;
		int on [2];
		int off [2];
		void'($sscanf(line, "B %d %d %d %d %d %d %d %d", syncAt, segs, on[0], off[0],
			on[1], off[1], expStart, expEnd));
		bcnStart.delete();
		bcnEnd.delete();
		laserSign = 1'b0;
		repeat (syncAt) laserStep();
		laserSync = 1'b1;
		repeat (2) @(negedge CLOCK_50);
		laserSync = 1'b0;
		lastPos = off[segs-1] + `BCN_GAP_EDGES + 3;
		for (int p = 0; p <= lastPos; p++)
		begin
			for (int k = 0; k < segs; k++)
			begin
				if (p == on[k])
					laserSign = 1'b1;
				if (p == off[k])
					laserSign = 1'b0;
			end
			laserStep();
		end
		waited = 0;
		while (bcnStart.size() == 0 && waited < 40)
		begin
			@(negedge CLOCK_50);
			waited++;
		end
		repeat (4) @(negedge CLOCK_50);
		assert (bcnStart.size() == 1)
		else
		begin
			$display("%s: %0d beacon results instead of one", name, bcnStart.size());
			testErrors++;
		end
		if (bcnStart.size() > 0)
		begin
			checkValue(name, "beacon start", expStart, bcnStart[0]);
			checkValue(name, "beacon end", expEnd, bcnEnd[0]);
		end
		finishTest(name);
	endtask

	initial
	begin
		int    fd;
		int    nWin;
		int    nBcn;
		string line;
		void'($urandom(32'hd5dc_4b19));
		reset        = 1'b1;
		encA         = '0;
		encB         = '0;
		laserA       = 1'b0;
		laserSync    = 1'b0;
		laserSign    = 1'b0;
		creditReturn = 1'b0;
		cycLimit     = 0;
		withhold     = 1'b0;
		kept         = 0;
		nWin         = 0;
		nBcn         = 0;
		fd = $fopen("verif/odometryTop_golden.txt", "r");
		if (fd == 0)
		begin
			$display("golden file verif/odometryTop_golden.txt could not be opened");
			failed++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 0 && line.getc(0) == "S")
					nWin++;
				if (line.len() > 0 && line.getc(0) == "B")
					nBcn++;
				if (line.len() > 0 && (line.getc(0) == "S" || line.getc(0) == "B"))
					recs.push_back(line);
			end
			$fclose(fd);
		end
		cycLimit = (nWin + 2) * Window + 400 * nBcn;

		repeat (10) @(negedge CLOCK_50);
		reset = 1'b0;
		@(negedge CLOCK_50);
		checkValue("reset", "reportValid", 0, int'(reportValid));
		checkValue("reset", "beaconValid", 0, int'(beaconValid));
		checkValue("reset", "overrun", 0, int'(overrun));
		finishTest("reset");

		foreach (recs[i])
			if (recs[i].getc(0) == "B")
				runBeacon(recs[i], $sformatf("beacon%0d", i));
			else
				runSpeed(recs[i], $sformatf("speed%0d", i));

		$display("%0d tests, %0d passed, %0d failed", passed + failed, passed, failed);
		if (failed == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== verif/odometryTop_golden.txt ====
# beacon: B syncAt segments on0 off0 on1 off1 expStart expEnd
# positions in laser edges after the sync pulse, unused segment given as 0 0
B 7 1 12 30 0 0 12 30
B 3 2 8 20 25 41 8 41
B 5 2 10 16 35 42 10 42
# speed: S mode cycles0 dir0 cycles1 dir1 cycles2 dir2 cycles3 dir3
# dir 1 forward, 0 reverse
# mode 0 credits returned
# mode 1 reports checked, credits then held
# mode 2 held credits block the reports, then released
# mode 3 held through the window, result overwritten by the next one
S 0 3 1 5 0 8 1 1 0
S 0 7 0 2 1 4 1 6 0
S 1 4 1 4 1 2 0 8 1
S 2 6 0 1 1 3 0 5 1
S 1 2 1 2 1 2 1 2 1
S 3 8 0 8 0 8 0 8 0
S 2 5 1 6 0 7 1 8 0
S 0 1 0 3 1 5 0 7 1

// ==== odometryTop.f ====
+incdir+hdl
hdl/odoPkg.sv
hdl/encoderSampler.sv
hdl/speedChannel.sv
hdl/reportArbiter.sv
hdl/beaconTracker.sv
hdl/odometryTop.sv
verif/odometryTop_props.sv
verif/odometryTop_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the odometry testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module odometryTop_tb -f odometryTop.f \
	--Mdir obj_dir -o odometryTop_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/odometryTop_sim > sim.log 2>&1
grep -qx "Test OK" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
